//--- verilog/idctNumericPkg.sv
`default_nettype none

package idctNumericPkg;

   // data word used for input, intermediate and output blocks
   typedef logic signed [31:0] sampleT;

   // cosine coefficient, two's complement
   typedef logic signed [15:0] coefT;

   // low coefficient bits zeroed before the row multiply
   localparam int rowCoefCut = 8;

   // low bits shifted out of both column operands
   localparam int colOperandCut = 8;

   // arithmetic shift applied to each product
   localparam int productShift = 3;

   // scaled cosine basis, row-major, stored as raw 16-bit patterns
   localparam logic [15:0] cosTable [64] = '{
      16'd23170, 16'd32138, 16'd30274, 16'd27246, 16'd23170, 16'd18205, 16'd12540, 16'd6393,
      16'd23170, 16'd27246, 16'd12540, 16'd59143, 16'd42366, 16'd33398, 16'd35262, 16'd47331,
      16'd23170, 16'd18205, 16'd52996, 16'd33398, 16'd42366, 16'd6393, 16'd30274, 16'd27246,
      16'd23170, 16'd6393, 16'd35262, 16'd47331, 16'd23170, 16'd27246, 16'd52996, 16'd33398,
      16'd23170, 16'd59143, 16'd35262, 16'd18205, 16'd23170, 16'd38290, 16'd52996, 16'd32138,
      16'd23170, 16'd47331, 16'd52996, 16'd32138, 16'd42366, 16'd59143, 16'd30274, 16'd38290,
      16'd23170, 16'd38290, 16'd12540, 16'd6393, 16'd42366, 16'd32138, 16'd35262, 16'd18205,
      16'd23170, 16'd33398, 16'd30274, 16'd38290, 16'd23170, 16'd47331, 16'd12540, 16'd59143
   };

   // values above 32767 come back negative
   function automatic coefT cosCoef(input logic [2:0] row, input logic [2:0] col);
      return coefT'(cosTable[{row, col}]);
   endfunction

endpackage

`default_nettype wire

//--- verilog/idctControlPkg.sv
`default_nettype none

package idctControlPkg;

   // row or column inside an 8x8 block
   typedef logic [2:0] blockIdxT;

   // row-major element index, row in the upper three bits
   typedef logic [5:0] elemIdxT;

   // pass counter, fields {i, j, k} from high to low
   typedef logic [8:0] macCountT;

   localparam int blockElems = 64;

   typedef enum logic [2:0] {
      idle,
      rowPass,
      rowDrain,
      colPass,
      colDrain
   } engineStateT;

endpackage

`default_nettype wire

//--- verilog/idctLoader.sv
`default_nettype none

module idctLoader (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    blockFreed,
   output logic                    reading,
   output logic                    loadDone,
   output logic                    wrEn,
   output idctControlPkg::elemIdxT wrIdx
);

   import idctControlPkg::*;

   // held from start until the streamer hands the block back
   logic busy;

   assign wrEn = reading;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy     <= 1'b0;
         reading  <= 1'b0;
         loadDone <= 1'b0;
         wrIdx    <= '0;
      end
      else
      begin
         loadDone <= 1'b0;
         if (!busy && start)
         begin
            busy    <= 1'b1;
            reading <= 1'b1;
            wrIdx   <= '0;
         end
         else if (reading)
         begin
            wrIdx <= wrIdx + elemIdxT'(1);
            // last word goes in on this edge
            if (wrIdx == elemIdxT'(blockElems - 1))
            begin
               reading  <= 1'b0;
               loadDone <= 1'b1;
            end
         end
         else if (blockFreed)
         begin
            busy <= 1'b0;
         end
      end
   end

   // engine is only kicked once the whole block is stored
   loadDoneAfterRead: assert property (@(posedge clk) disable iff (reset)
      !(loadDone && reading));

endmodule

`default_nettype wire

//--- verilog/idctBlockStore.sv
`default_nettype none

module idctBlockStore (
   input  logic                     clk,

   input  logic                     inWrEn,
   input  idctControlPkg::elemIdxT  inWrIdx,
   input  idctNumericPkg::sampleT   inWrData,

   input  idctControlPkg::blockIdxT inRdRow,
   input  idctControlPkg::blockIdxT inRdCol,
   output idctNumericPkg::sampleT   inRdData,
   input  idctControlPkg::blockIdxT tempRdRow,
   input  idctControlPkg::blockIdxT tempRdCol,
   output idctNumericPkg::sampleT   tempRdData,

   input  logic                     tempWrEn,
   input  idctControlPkg::blockIdxT tempWrRow,
   input  idctControlPkg::blockIdxT tempWrCol,
   input  idctNumericPkg::sampleT   tempWrData,
   input  logic                     outWrEn,
   input  idctControlPkg::blockIdxT outWrRow,
   input  idctControlPkg::blockIdxT outWrCol,
   input  idctNumericPkg::sampleT   outWrData,

   input  idctControlPkg::elemIdxT  outRdIdx,
   output idctNumericPkg::sampleT   outRdData
);

   import idctNumericPkg::*;
   import idctControlPkg::*;

   sampleT inBlock   [8][8];
   sampleT tempBlock [8][8];
   sampleT outBlock  [8][8];

   blockIdxT inWrRow, inWrCol;
   blockIdxT outRdRow, outRdCol;

   assign {inWrRow, inWrCol}   = inWrIdx;
   assign {outRdRow, outRdCol} = outRdIdx;

   always_ff @(posedge clk)
   begin
      if (inWrEn)
         inBlock[inWrRow][inWrCol] <= inWrData;
   end

   always_ff @(posedge clk)
   begin
      if (tempWrEn)
         tempBlock[tempWrRow][tempWrCol] <= tempWrData;
   end

   always_ff @(posedge clk)
   begin
      if (outWrEn)
         outBlock[outWrRow][outWrCol] <= outWrData;
   end

   // reads are combinational
   assign inRdData   = inBlock[inRdRow][inRdCol];
   assign tempRdData = tempBlock[tempRdRow][tempRdCol];
   assign outRdData  = outBlock[outRdRow][outRdCol];

   // the two passes never overlap
   onePassWrites: assert property (@(posedge clk) !(tempWrEn && outWrEn));

endmodule

`default_nettype wire

//--- verilog/idctMacEngine.sv
`default_nettype none

module idctMacEngine (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     loadDone,
   output logic                     computeDone,
   output idctControlPkg::blockIdxT inRdRow,
   output idctControlPkg::blockIdxT inRdCol,
   input  idctNumericPkg::sampleT   inRdData,
   output idctControlPkg::blockIdxT tempRdRow,
   output idctControlPkg::blockIdxT tempRdCol,
   input  idctNumericPkg::sampleT   tempRdData,
   output logic                     tempWrEn,
   output idctControlPkg::blockIdxT tempWrRow,
   output idctControlPkg::blockIdxT tempWrCol,
   output idctNumericPkg::sampleT   tempWrData,
   output logic                     outWrEn,
   output idctControlPkg::blockIdxT outWrRow,
   output idctControlPkg::blockIdxT outWrCol,
   output idctNumericPkg::sampleT   outWrData
);

   import idctNumericPkg::*;
   import idctControlPkg::*;

   engineStateT state;

   // count0 addresses operands, count3 lines up with the accumulator
   macCountT count0, count1, count2, count3;
   blockIdxT i0, j0, k0;
   blockIdxT i3, j3, k3;

   sampleT opA;
   coefT   opB;
   sampleT prod, sum, sumNext;
   sampleT rowCoef, colA, colB, product, wrData;
   logic   readTemp, drain, lastTerm;

   assign {i0, j0, k0} = count0;
   assign {i3, j3, k3} = count3;

   // the column pass and its preload read the intermediate block
   assign readTemp = (state == rowDrain) || (state == colPass);

   assign inRdRow   = j0;
   assign inRdCol   = k0;
   assign tempRdRow = k0;
   assign tempRdCol = i0;

   always_ff @(posedge clk)
   begin
      opA <= readTemp ? tempRdData : inRdData;
      opB <= cosCoef(readTemp ? j0 : i0, k0);
   end

   // row pass zeroes the low coefficient bits but keeps its scale
   assign rowCoef = (sampleT'(opB) >>> rowCoefCut) <<< rowCoefCut;
   assign colA    = opA >>> colOperandCut;
   assign colB    = sampleT'(opB) >>> colOperandCut;
   assign product = (state == colPass) ? colA * colB : opA * rowCoef;

   assign sumNext  = sum + prod;
   assign lastTerm = (k3 == blockIdxT'(7));
   assign drain    = (state == rowDrain) || (state == colDrain);

   // drain cycles still owe the newest product
   assign wrData = drain ? sumNext : sum;

   assign tempWrEn   = ((state == rowPass) && lastTerm) || (state == rowDrain);
   assign tempWrRow  = j3;
   assign tempWrCol  = i3;
   assign tempWrData = wrData;
   assign outWrEn    = ((state == colPass) && lastTerm) || (state == colDrain);
   assign outWrRow   = j3;
   assign outWrCol   = i3;
   assign outWrData  = wrData;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state       <= idle;
         count0      <= '0;
         count1      <= '0;
         count2      <= '0;
         count3      <= '0;
         prod        <= '0;
         sum         <= '0;
         computeDone <= 1'b0;
      end
      else
      begin
         computeDone <= (state == colDrain);
         case (state)
            idle:
            begin
               // operands for (0, 0, 0) are already loaded
               if (loadDone)
               begin
                  count0 <= macCountT'(1);
                  count1 <= '0;
                  count2 <= '0;
                  count3 <= '0;
                  prod   <= '0;
                  sum    <= '0;
                  state  <= rowPass;
               end
            end
            rowPass, colPass:
            begin
               count1 <= count0;
               count2 <= count1;
               count3 <= count2;
               prod   <= product >>> productShift;
               sum    <= lastTerm ? prod : sumNext;
               // counter wrapped, hold at zero for the next preload
               if (count0 == '0)
                  state <= (state == rowPass) ? rowDrain : colDrain;
               else
                  count0 <= count0 + macCountT'(1);
            end
            rowDrain:
            begin
               count0 <= macCountT'(1);
               count1 <= '0;
               count2 <= '0;
               count3 <= '0;
               prod   <= '0;
               sum    <= '0;
               state  <= colPass;
            end
            colDrain:
            begin
               state <= idle;
            end
            default:
            begin
               state <= idle;
            end
         endcase
      end
   end

   // a block only starts once the loader has finished
   idleUntilLoad: assert property (@(posedge clk) disable iff (reset)
      (state == idle && !loadDone) |=> (state == idle));

endmodule

`default_nettype wire

//--- verilog/idctStreamer.sv
`default_nettype none

module idctStreamer (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    computeDone,
   output idctControlPkg::elemIdxT outRdIdx,
   input  idctNumericPkg::sampleT  outRdData,
   output logic                    done,
   output idctNumericPkg::sampleT  dout,
   output logic                    blockFreed
);

   import idctControlPkg::*;

   elemIdxT count;

   assign outRdIdx = count;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         done       <= 1'b0;
         count      <= '0;
         dout       <= '0;
         blockFreed <= 1'b0;
      end
      else
      begin
         blockFreed <= 1'b0;
         if (computeDone)
         begin
            done  <= 1'b1;
            count <= '0;
         end
         else if (done)
         begin
            dout  <= outRdData;
            count <= count + elemIdxT'(1);
            // last word out, release the loader
            if (count == elemIdxT'(blockElems - 1))
            begin
               done       <= 1'b0;
               blockFreed <= 1'b1;
            end
         end
      end
   end

   // loader holds off the next block until blockFreed
   noOverlappingBlocks: assert property (@(posedge clk) disable iff (reset)
      !(computeDone && done));

endmodule

`default_nettype wire

//--- verilog/idct.sv
`default_nettype none

module idct (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  idctNumericPkg::sampleT din,
   output logic                   reading,
   output logic                   done,
   output idctNumericPkg::sampleT dout
);

   import idctNumericPkg::*;
   import idctControlPkg::*;

   logic     loadDone, computeDone, blockFreed;
   logic     inWrEn, tempWrEn, outWrEn;
   elemIdxT  inWrIdx, outRdIdx;
   blockIdxT inRdRow, inRdCol, tempRdRow, tempRdCol;
   blockIdxT tempWrRow, tempWrCol, outWrRow, outWrCol;
   sampleT   inRdData, tempRdData, tempWrData, outWrData, outRdData;

   idctLoader loader (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .blockFreed (blockFreed),
      .reading    (reading),
      .loadDone   (loadDone),
      .wrEn       (inWrEn),
      .wrIdx      (inWrIdx)
   );

   idctBlockStore blockStore (
      .clk        (clk),
      .inWrEn     (inWrEn),
      .inWrIdx    (inWrIdx),
      .inWrData   (din),
      .inRdRow    (inRdRow),
      .inRdCol    (inRdCol),
      .inRdData   (inRdData),
      .tempRdRow  (tempRdRow),
      .tempRdCol  (tempRdCol),
      .tempRdData (tempRdData),
      .tempWrEn   (tempWrEn),
      .tempWrRow  (tempWrRow),
      .tempWrCol  (tempWrCol),
      .tempWrData (tempWrData),
      .outWrEn    (outWrEn),
      .outWrRow   (outWrRow),
      .outWrCol   (outWrCol),
      .outWrData  (outWrData),
      .outRdIdx   (outRdIdx),
      .outRdData  (outRdData)
   );

   idctMacEngine macEngine (
      .clk         (clk),
      .reset       (reset),
      .loadDone    (loadDone),
      .computeDone (computeDone),
      .inRdRow     (inRdRow),
      .inRdCol     (inRdCol),
      .inRdData    (inRdData),
      .tempRdRow   (tempRdRow),
      .tempRdCol   (tempRdCol),
      .tempRdData  (tempRdData),
      .tempWrEn    (tempWrEn),
      .tempWrRow   (tempWrRow),
      .tempWrCol   (tempWrCol),
      .tempWrData  (tempWrData),
      .outWrEn     (outWrEn),
      .outWrRow    (outWrRow),
      .outWrCol    (outWrCol),
      .outWrData   (outWrData)
   );

   idctStreamer streamer (
      .clk         (clk),
      .reset       (reset),
      .computeDone (computeDone),
      .outRdIdx    (outRdIdx),
      .outRdData   (outRdData),
      .done        (done),
      .dout        (dout),
      .blockFreed  (blockFreed)
   );

endmodule

`default_nettype wire

//--- dv/idctRefModel.svh
`ifndef IDCT_REF_MODEL_SVH
`define IDCT_REF_MODEL_SVH

// table entry widened to 32 bits, sign kept
function automatic int refCoef(input int row, input int col);
   coefT raw;
   raw = cosCoef(3'(row), 3'(col));
   return int'(raw);
endfunction

// row term, coefficient keeps its scale with the low byte cleared
function automatic int rowTerm(input int sample, input int coef);
   int     masked;
   longint wide;
   masked = coef & 32'hffff_ff00;
   wide = longint'(sample) * longint'(masked);
   return int'(wide) >>> 3;
endfunction

// column term, both operands lose their low byte
function automatic int colTerm(input int sample, input int coef);
   longint wide;
   wide = longint'(sample >>> 8) * longint'(coef >>> 8);
   return int'(wide) >>> 3;
endfunction

// intermediate element (j, i), sum wraps at 32 bits
function automatic int rowPassElem(input int blk [64], input int j, input int i);
   int sum;
   sum = 0;
   for (int k = 0; k < 8; k++)
      sum = sum + rowTerm(blk[j * 8 + k], refCoef(i, k));
   return sum;
endfunction

// output element (j, i) from the intermediate block
function automatic int colPassElem(input int blk [64], input int j, input int i);
   int sum;
   sum = 0;
   for (int k = 0; k < 8; k++)
      sum = sum + colTerm(blk[k * 8 + i], refCoef(j, k));
   return sum;
endfunction

`endif

//--- dv/idctTb.sv
`default_nettype none

module idctTb;

   import idctNumericPkg::*;
   import idctControlPkg::*;

   `include "idctRefModel.svh"

   localparam int clkPeriod    = 40;
   localparam int resetCycles  = 16;
   localparam int tableRows    = 5;
   localparam int cyclesPerRow = 1300;

   typedef enum logic [1:0] {patZero, patDc, patImpulse, patRandom} patternT;

   typedef struct packed {
      patternT            pattern;
      logic signed [31:0] amplitude;
   } stimRowT;

   // amplitude 0 on a random row means the full 32-bit range
   stimRowT stimTable [tableRows] = '{
      '{patZero,    0},
      '{patDc,      12345},
      '{patImpulse, -40000},
      '{patRandom,  3000},
      '{patRandom,  0}
   };

   logic   clk;
   logic   reset;
   logic   start;
   sampleT din;
   logic   reading;
   logic   done;
   sampleT dout;

   int inWords   [64];
   int tempWords [64];
   int expWords  [64];

   idct idct_inst (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .din     (din),
      .reading (reading),
      .done    (done),
      .dout    (dout)
   );

   initial clk = 1'b0;

   always #(clkPeriod / 2) clk = ~clk;

   initial
   begin
      #((resetCycles + tableRows * cyclesPerRow) * clkPeriod);
      $display("timeout: the blocks did not finish within %0d cycles",
         resetCycles + tableRows * cyclesPerRow);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected)
      begin
         $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what,
            $signed(actual), $signed(expected));
         $display("sim failed");
         $fatal(1, "check failed");
      end
   endtask

   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic buildBlock(input stimRowT row);
      int          n;
      int unsigned span;
      span = 2 * row.amplitude + 1;
      for (n = 0; n < blockElems; n++)
      begin
         case (row.pattern)
            patZero:    inWords[n] = 0;
            patDc:      inWords[n] = (n == 0) ? row.amplitude : 0;
            patImpulse: inWords[n] = (n == 3 * 8 + 5) ? row.amplitude : 0;
            default:
            begin
               if (row.amplitude == 0)
                  inWords[n] = int'($urandom);
               else
                  inWords[n] = int'($urandom % span) - row.amplitude;
            end
         endcase
      end
   endtask

   task automatic computeExpected();
      int j;
      int i;
      for (j = 0; j < 8; j++)
         for (i = 0; i < 8; i++)
            tempWords[j * 8 + i] = rowPassElem(inWords, j, i);
      for (j = 0; j < 8; j++)
         for (i = 0; i < 8; i++)
            expWords[j * 8 + i] = colPassElem(tempWords, j, i);
   endtask

   task automatic loadBlock();
      int n;
      checkValue(32'(reading), 0, "reading low before start");
      start = 1'b1;
      nextCycle();
      start = 1'b0;
      checkValue(32'(reading), 1, "reading one edge after start");
      for (n = 0; n < blockElems; n++)
      begin
         din = inWords[n];
         // extra start in the middle of the load
         start = (n == 20);
         checkValue(32'(reading), 1, "reading held during load");
         nextCycle();
      end
      start = 1'b0;
      din   = '0;
      checkValue(32'(reading), 0, "reading low after 64 words");
   endtask

   task automatic collectBlock(input int row);
      int n;
      int waitCycles;
      waitCycles = 0;
      while (!done)
      begin
         // start while the engine is busy
         start = (waitCycles == 10);
         checkValue(32'(reading), 0, "no second load while computing");
         nextCycle();
         waitCycles++;
      end
      start = 1'b0;
      for (n = 0; n < blockElems; n++)
      begin
         checkValue(32'(done), 1, "done held while streaming");
         nextCycle();
         checkValue(dout, expWords[n], $sformatf("block %0d word %0d", row, n));
      end
      checkValue(32'(done), 0, "done low after 64 words");
      // loader is released on the next edge
      nextCycle();
   endtask

   initial
   begin
      int row;
      reset = 1'b1;
      start = 1'b0;
      din   = '0;
      void'($urandom(32'h6bd7));
      repeat (resetCycles) @(posedge clk);
      #1;
      reset = 1'b0;
      checkValue(32'(reading), 0, "reading after reset");
      checkValue(32'(done), 0, "done after reset");
      checkValue(dout, 0, "dout after reset");
      for (row = 0; row < tableRows; row++)
      begin
         buildBlock(stimTable[row]);
         computeExpected();
         loadBlock();
         collectBlock(row);
      end
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+dv
verilog/idctNumericPkg.sv
verilog/idctControlPkg.sv
verilog/idctLoader.sv
verilog/idctBlockStore.sv
verilog/idctMacEngine.sv
verilog/idctStreamer.sv
verilog/idct.sv
dv/idctTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module idctTb -f project.f || exit 1
result=$(./obj_dir/VidctTb)
echo "$result"
echo "$result" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
